//--- bench/lspChebTb.sv
`default_nettype none

`include "lspCheb_config.svh"

module lspChebTb
	import lspChebPkg::*;
();

	// Random, all max, all min, reload and start while busy sweeps
	localparam int SWEEP_COUNT = 5;
	localparam int TIMEOUT_CYCLES = SWEEP_COUNT * `GRID_POINTS * 30 + 200;

	typedef logic [`COEFF_COUNT:1][15:0] coeffVec;

	logic clk;
	logic reset;
	logic coeffWrite;
	coeffIndex coeffAddr;
	word16 coeffData;
	logic sweepStart;
	logic resultValid;
	word16 resultValue;
	gridIndex resultIndex;
	logic sweepDone;
	logic busy;

	coeffVec refCoeffs;
	integer seed;
	int resultsSeen;
	int cycleCount;
	logic sweepActive;
	word16 expValue;
	int valueErrors;
	int indexErrors;
	int flagErrors;
	int protocolErrors;
	int totalErrors;

	lspCheb UUT (
		.clk(clk), .reset(reset), .coeffWrite(coeffWrite), .coeffAddr(coeffAddr),
		.coeffData(coeffData), .sweepStart(sweepStart), .resultValid(resultValid),
		.resultValue(resultValue), .resultIndex(resultIndex),
		.sweepDone(sweepDone), .busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model of the basic operators
	//////////////////////////////////////////////////////////////////////
	function automatic word32 satL(input longint v);
		if (v > 64'sd2147483647)
			return 32'sh7FFF_FFFF;
		if (v < -64'sd2147483648)
			return 32'sh8000_0000;
		return word32'(v);
	endfunction

	function automatic word32 refLMult(input word16 a, input word16 b);
		if (a == 16'sh8000 && b == 16'sh8000)
			return 32'sh7FFF_FFFF;
		return word32'(2 * longint'(a) * longint'(b));
	endfunction

	function automatic word16 refMult(input word16 a, input word16 b);
		longint p;
		p = (longint'(a) * longint'(b)) >>> 15;
		if (p > 32767)
			return 16'sh7FFF;
		if (p < -32768)
			return 16'sh8000;
		return word16'(p);
	endfunction

	function automatic word32 refLMac(input word32 c, input word16 a, input word16 b);
		return satL(longint'(c) + longint'(refLMult(a, b)));
	endfunction

	function automatic word32 refLMsu(input word32 c, input word16 a, input word16 b);
		return satL(longint'(c) - longint'(refLMult(a, b)));
	endfunction

	function automatic word32 refLShl(input word32 v, input int n);
		return satL(longint'(v) <<< n);
	endfunction

	// Low half of the pair as an unsigned halved value
	function automatic word16 loOf(input word32 t);
		return word16'((t & 32'h0000_FFFF) >> 1);
	endfunction

	function automatic word32 refMpy(input word16 hi, input word16 lo, input word16 x);
		return refLMac(refLMult(hi, x), refMult(lo, x), 16'sd1);
	endfunction

	// Chebyshev series value at x for coefficients f1..f5
	function automatic word16 chebRef(input word16 x, input coeffVec f);
		word16 b1Hi;
		word16 b1Lo;
		word16 b2Hi;
		word16 b2Lo;
		word32 t0;
		b2Hi = 16'sd256;
		b2Lo = 16'sd0;
		t0 = refLMac(refLMult(x, 16'sd512), word16'(f[1]), 16'sd4096);
		b1Hi = t0[31:16];
		b1Lo = loOf(t0);
		for (int i = 2; i < `POLY_ORDER; i++)
		begin
			t0 = refLShl(refMpy(b1Hi, b1Lo, x), 1);
			t0 = refLMac(t0, b2Hi, 16'sh8000);
			t0 = refLMsu(t0, b2Lo, 16'sd1);
			t0 = refLMac(t0, word16'(f[i]), 16'sd4096);
			b2Hi = b1Hi;
			b2Lo = b1Lo;
			b1Hi = t0[31:16];
			b1Lo = loOf(t0);
		end
		t0 = refMpy(b1Hi, b1Lo, x);
		t0 = refLMac(t0, b2Hi, 16'sh8000);
		t0 = refLMsu(t0, b2Lo, 16'sd1);
		t0 = refLMac(t0, word16'(f[`POLY_ORDER]), 16'sd2048);
		t0 = refLShl(t0, 6);
		return t0[31:16];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic checkValue(input word16 actual, input word16 expected, input int pos);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("[FAIL] %0t: value at grid %0d is %0d, expected %0d",
				$time, pos, actual, expected);
		end
	endtask

	task automatic checkIndex(input gridIndex actual, input gridIndex expected);
		if (actual !== expected)
		begin
			indexErrors++;
			$display("[FAIL] %0t: result index %0d, expected %0d", $time, actual, expected);
		end
	endtask

	task automatic checkFlag(input logic actual, input logic expected, input string name);
		if (actual !== expected)
		begin
			flagErrors++;
			$display("[FAIL] %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	// Sample settled outputs on the falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (resultValid)
			begin
				if (!sweepActive || resultsSeen >= `GRID_POINTS)
				begin
					protocolErrors++;
					$display("Extra result pulse at time %0t outside a sweep", $time);
				end
				else
				begin
					expValue = chebRef(cosGrid[resultsSeen], refCoeffs);
					checkValue(resultValue, expValue, resultsSeen);
					checkIndex(resultIndex, gridIndex'(resultsSeen));
					checkFlag(busy, 1'b1, "busy during sweep");
					resultsSeen++;
				end
			end
			if (resultValid && sweepActive && resultsSeen == `GRID_POINTS)
				checkFlag(sweepDone, 1'b1, "sweepDone on last result");
			else if (sweepDone)
			begin
				protocolErrors++;
				$display("sweepDone at time %0t came without the last result", $time);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////
	task automatic writeCoeff(input coeffIndex addr, input word16 data);
		@(posedge clk);
		#10;
		coeffWrite = 1'b1;
		coeffAddr = addr;
		coeffData = data;
		@(posedge clk);
		#10;
		coeffWrite = 1'b0;
		// Only entries 1 to 5 exist
		if (addr >= 1 && addr <= `COEFF_COUNT)
			refCoeffs[addr] = data;
	endtask

	task automatic pulseStart();
		@(posedge clk);
		#10 sweepStart = 1'b1;
		@(posedge clk);
		#10 sweepStart = 0;
	endtask

	task automatic runSweep(input logic restartMid);
		resultsSeen = 0;
		sweepActive = 1'b1;
		pulseStart();
		if (restartMid)
		begin
			while (resultsSeen < 10)
				@(negedge clk);
			pulseStart();
		end
		do
			@(negedge clk);
		while (!sweepDone);
		@(posedge clk);
		#10;
		if (resultsSeen != `GRID_POINTS)
		begin
			protocolErrors++;
			$display("Sweep ended after %0d results instead of %0d",
				resultsSeen, `GRID_POINTS);
		end
		checkFlag(busy, 1'b0, "busy after sweepDone");
		sweepActive = 1'b0;
	endtask

	initial
	begin
		reset = 1'b1;
		coeffWrite = 1'b0;
		coeffAddr = '0;
		coeffData = '0;
		sweepStart = 1'b0;
		refCoeffs = '0;
		seed = 36500;
		resultsSeen = 0;
		sweepActive = 1'b0;
		valueErrors = 0;
		indexErrors = 0;
		flagErrors = 0;
		protocolErrors = 0;
		repeat (16)
			@(posedge clk);
		#10 reset = 1'b0;

		// Quiet outputs until the first start
		repeat (20)
		begin
			@(negedge clk);
			checkFlag(resultValid, 1'b0, "resultValid after reset");
			checkFlag(sweepDone, 1'b0, "sweepDone after reset");
			checkFlag(busy, 1'b0, "busy after reset");
		end

		for (int i = 1; i <= `COEFF_COUNT; i++)
			writeCoeff(coeffIndex'(i), word16'($random(seed)));
		runSweep(1'b0);

		// Extreme coefficients
		for (int i = 1; i <= `COEFF_COUNT; i++)
			writeCoeff(coeffIndex'(i), 16'sh7FFF);
		runSweep(1'b0);
		for (int i = 1; i <= `COEFF_COUNT; i++)
			writeCoeff(coeffIndex'(i), 16'sh8000);
		runSweep(1'b0);

		// Reload and then write outside the bank
		for (int i = 1; i <= `COEFF_COUNT; i++)
			writeCoeff(coeffIndex'(i), word16'($random(seed)));
		writeCoeff(3'd0, 16'sh1234);
		writeCoeff(3'd7, 16'sh5678);
		runSweep(1'b0);

		runSweep(1'b1);
		repeat (10)
			@(posedge clk);

		totalErrors = valueErrors + indexErrors + flagErrors + protocolErrors;
		$display("Errors: value %0d, index %0d, flag %0d, protocol %0d",
			valueErrors, indexErrors, flagErrors, protocolErrors);
		if (totalErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Run limit from the number of sweeps
	initial
	begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: sweeps did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- lspCheb.f
+incdir+source
source/lspChebPkg.sv
source/basicOps.sv
source/coeffBank.sv
source/gridSweep.sv
source/chebEvaluator.sv
source/lspCheb.sv
bench/lspChebTb.sv

//--- source/basicOps.sv
`default_nettype none

module basicOps
	import lspChebPkg::*;
(
	input wire clk,
	input wire reset,
	input wire word16 lMultA,
	input wire word16 lMultB,
	output word32 lMultOut,
	input wire word16 multA,
	input wire word16 multB,
	output word16 multOut,
	input wire word16 lMacA,
	input wire word16 lMacB,
	input wire word32 lMacC,
	output word32 lMacOut,
	input wire word16 lMsuA,
	input wire word16 lMsuB,
	input wire word32 lMsuC,
	output word32 lMsuOut,
	input wire word32 lShlVar,
	input wire logic [3:0] lShlShift,
	input wire lShlReady,
	output logic lShlDone,
	output word32 lShlOut
);

	//////////////////////////////////////////////////////////////////////
	// Saturating operator functions
	//////////////////////////////////////////////////////////////////////

	// 2ab, the only overflow is -1 * -1
	function automatic word32 lMultF(input word16 a, input word16 b);
		word32 prod;
		prod = a * b;
		if (prod == 32'sh4000_0000)
			return 32'sh7FFF_FFFF;
		return prod <<< 1;
	endfunction

	function automatic word16 multF(input word16 a, input word16 b);
		word32 prod;
		logic signed [16:0] scaled;
		prod = a * b;
		scaled = 17'(prod >>> 15);
		if (scaled[16] != scaled[15])
			return scaled[16] ? 16'sh8000 : 16'sh7FFF;
		return scaled[15:0];
	endfunction

	// Sum or difference clipped to 32 bits
	function automatic word32 lAddF(input word32 a, input word32 b, input logic sub);
		logic signed [32:0] sum;
		sum = sub ? (a - b) : (a + b);
		if (sum[32] != sum[31])
			return sum[32] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
		return sum[31:0];
	endfunction

	function automatic word32 lShlF(input word32 v, input logic [3:0] n);
		logic signed [47:0] wide;
		wide = v;
		wide = wide <<< n;
		// Any lost bit that differs from the sign means overflow
		if (wide[47:31] != {17{wide[47]}})
			return wide[47] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
		return wide[31:0];
	endfunction

	assign lMultOut = lMultF(lMultA, lMultB);
	assign multOut = multF(multA, multB);
	assign lMacOut = lAddF(lMacC, lMultF(lMacA, lMacB), 1'b0);
	assign lMsuOut = lAddF(lMsuC, lMultF(lMsuA, lMsuB), 1'b1);

	//////////////////////////////////////////////////////////////////////
	// L_shl, one request per rising ready
	//////////////////////////////////////////////////////////////////////
	logic lShlArmed;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lShlDone <= 1'b0;
			lShlArmed <= 1'b0;
		end
		else
		begin
			lShlDone <= lShlReady && !lShlArmed;
			lShlArmed <= lShlReady;
		end
	end

	// Result held until the next request
	always_ff @(posedge clk)
	begin
		if (lShlReady && !lShlArmed)
			lShlOut <= lShlF(lShlVar, lShlShift);
	end

endmodule

`default_nettype wire

//--- source/chebEvaluator.sv
`default_nettype none

`include "lspCheb_config.svh"

module chebEvaluator
	import lspChebPkg::*;
(
	input wire clk,
	input wire reset,
	input wire evalStart,
	input wire word16 xValue,
	output coeffIndex coeffSel,
	input wire word16 coeffOut,
	output word16 lMultA,
	output word16 lMultB,
	input wire word32 lMultOut,
	output word16 multA,
	output word16 multB,
	input wire word16 multOut,
	output word16 lMacA,
	output word16 lMacB,
	output word32 lMacC,
	input wire word32 lMacOut,
	output word16 lMsuA,
	output word16 lMsuB,
	output word32 lMsuC,
	input wire word32 lMsuOut,
	output word32 lShlVar,
	output logic [3:0] lShlShift,
	output logic lShlReady,
	input wire lShlDone,
	input wire word32 lShlOut,
	output logic evalDone,
	output word16 chebValue
);

	typedef enum logic [3:0] {
		stateIdle, stateMath0, stateLoop1, stateLoop2, stateLoop3,
		stateMath1, stateMath2, stateMath3, stateMath4
	} evalState;

	evalState state;
	coeffIndex count;
	logic shlDoneReg;
	word16 x;
	word32 t0;
	word16 b1Hi, b1Lo, b2Hi, b2Lo;

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			count <= 3'd2;
			shlDoneReg <= 1'b0;
			evalDone <= 1'b0;
		end
		else
		begin
			evalDone <= 1'b0;
			if (lShlDone)
				shlDoneReg <= 1'b1;
			case (state)
				stateIdle:
					if (evalStart)
					begin
						count <= 3'd2;
						shlDoneReg <= 1'b0;
						state <= stateMath0;
					end
				stateMath0:
					state <= stateLoop1;
				stateLoop1:
					state <= (count < `POLY_ORDER) ? stateLoop2 : stateMath1;
				stateLoop2:
					if (shlDoneReg)
					begin
						shlDoneReg <= 1'b0;
						state <= stateLoop3;
					end
				stateLoop3:
				begin
					count <= count + 3'd1;
					state <= stateLoop1;
				end
				stateMath1:
					state <= stateMath2;
				stateMath2:
					state <= stateMath3;
				stateMath3:
					state <= stateMath4;
				stateMath4:
					if (shlDoneReg)
					begin
						shlDoneReg <= 1'b0;
						evalDone <= 1'b1;
						state <= stateIdle;
					end
				default:
					state <= stateIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath registers, hi/lo extraction done here
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		case (state)
			stateIdle:
				if (evalStart)
					x <= xValue;
			stateMath0:
			begin
				t0 <= lMacOut;
				b1Hi <= lMacOut[31:16];
				b1Lo <= {1'b0, lMacOut[15:1]};
				b2Hi <= 16'sd256;
				b2Lo <= '0;
			end
			stateLoop1:
				if (count < `POLY_ORDER)
					t0 <= lMacOut;
			stateLoop2:
				if (shlDoneReg)
					t0 <= lMsuOut;
			stateLoop3:
			begin
				t0 <= lMacOut;
				b2Hi <= b1Hi;
				b2Lo <= b1Lo;
				b1Hi <= lMacOut[31:16];
				b1Lo <= {1'b0, lMacOut[15:1]};
			end
			stateMath1, stateMath3:
				t0 <= lMacOut;
			stateMath2:
				t0 <= lMsuOut;
			stateMath4:
				if (shlDoneReg)
					chebValue <= lShlOut[31:16];
			default:
				;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Operand routing to the shared operators
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		coeffSel = count;
		lMultA = '0;
		lMultB = '0;
		multA = '0;
		multB = '0;
		lMacA = '0;
		lMacB = '0;
		lMacC = '0;
		lMsuA = '0;
		lMsuB = '0;
		lMsuC = '0;
		lShlVar = t0;
		lShlShift = 4'd1;
		lShlReady = 1'b0;
		case (state)
			stateMath0:
			begin
				// L_mac(L_mult(x, 512), f1, 4096)
				coeffSel = 3'd1;
				lMultA = x;
				lMultB = 16'sd512;
				lMacA = coeffOut;
				lMacB = 16'sd4096;
				lMacC = lMultOut;
			end
			stateLoop1, stateMath1:
			begin
				// Mpy_32_16(b1, x)
				lMultA = b1Hi;
				lMultB = x;
				multA = b1Lo;
				multB = x;
				lMacA = multOut;
				lMacB = 16'sd1;
				lMacC = lMultOut;
			end
			stateLoop2, stateMath2:
			begin
				lShlReady = (state == stateLoop2) && !shlDoneReg;
				lMacA = b2Hi;
				lMacB = 16'sh8000;
				lMacC = (state == stateLoop2) ? lShlOut : t0;
				lMsuA = b2Lo;
				lMsuB = 16'sd1;
				lMsuC = lMacOut;
			end
			stateLoop3:
			begin
				lMacA = coeffOut;
				lMacB = 16'sd4096;
				lMacC = t0;
			end
			stateMath3:
			begin
				coeffSel = 3'(`POLY_ORDER);
				lMacA = coeffOut;
				lMacB = 16'sd2048;
				lMacC = t0;
			end
			stateMath4:
			begin
				lShlShift = 4'd6;
				lShlReady = !shlDoneReg;
			end
			default:
				;
		endcase
	end

endmodule

`default_nettype wire

//--- source/coeffBank.sv
`default_nettype none

`include "lspCheb_config.svh"

module coeffBank
	import lspChebPkg::*;
(
	input wire clk,
	input wire reset,
	input wire coeffWrite,
	input wire coeffIndex coeffAddr,
	input wire word16 coeffData,
	input wire coeffIndex coeffSel,
	output word16 coeffOut
);

	// Entries numbered from 1 like f1..f5
	word16 coeffs [1:`COEFF_COUNT];

	logic addrValid;
	logic selValid;

	assign addrValid = (coeffAddr >= 3'd1) && (coeffAddr <= 3'(`COEFF_COUNT));
	assign selValid = (coeffSel >= 3'd1) && (coeffSel <= 3'(`COEFF_COUNT));

	always_ff @(posedge clk)
	begin
		if (reset)
			coeffs <= '{default: '0};
		else if (coeffWrite && addrValid)
			coeffs[coeffAddr] <= coeffData;
	end

	// Out of range selects read as zero
	assign coeffOut = selValid ? coeffs[coeffSel] : '0;

endmodule

`default_nettype wire

//--- source/gridSweep.sv
`default_nettype none

`include "lspCheb_config.svh"

module gridSweep
	import lspChebPkg::*;
(
	input wire clk,
	input wire reset,
	input wire sweepStart,
	input wire evalDone,
	input wire word16 chebValue,
	output logic evalStart,
	output word16 xValue,
	output logic resultValid,
	output word16 resultValue,
	output gridIndex resultIndex,
	output logic sweepDone,
	output logic busy
);

	gridIndex gridPos;
	logic lastPoint;

	assign xValue = cosGrid[gridPos];
	assign lastPoint = (gridPos == 6'(`GRID_POINTS - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gridPos <= '0;
			busy <= 1'b0;
			evalStart <= 1'b0;
			resultValid <= 1'b0;
			sweepDone <= 1'b0;
		end
		else
		begin
			evalStart <= 1'b0;
			resultValid <= 1'b0;
			sweepDone <= 1'b0;
			// Start pulses are dropped while a sweep runs
			if (!busy && sweepStart)
			begin
				busy <= 1'b1;
				gridPos <= '0;
				evalStart <= 1'b1;
			end
			else if (busy && evalDone)
			begin
				resultValid <= 1'b1;
				if (lastPoint)
					sweepDone <= 1'b1;
				else
				begin
					gridPos <= gridPos + 6'd1;
					evalStart <= 1'b1;
				end
			end
			// Busy drops in the cycle after the final result
			if (sweepDone)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (evalDone)
		begin
			resultValue <= chebValue;
			resultIndex <= gridPos;
		end
	end

endmodule

`default_nettype wire

//--- source/lspCheb.sv
`default_nettype none

module lspCheb
	import lspChebPkg::*;
(
	input wire clk,
	input wire reset,
	input wire coeffWrite,
	input wire coeffIndex coeffAddr,
	input wire word16 coeffData,
	input wire sweepStart,
	output logic resultValid,
	output word16 resultValue,
	output gridIndex resultIndex,
	output logic sweepDone,
	output logic busy
);

	// Sweeper and evaluator
	logic evalStart, evalDone;
	word16 xValue, chebValue;

	// Coefficient read
	coeffIndex coeffSel;
	word16 coeffOut;

	// Shared operator operands and results
	word16 lMultA, lMultB, multA, multB, multOut;
	word16 lMacA, lMacB, lMsuA, lMsuB;
	word32 lMultOut, lMacC, lMacOut, lMsuC, lMsuOut, lShlVar, lShlOut;
	logic [3:0] lShlShift;
	logic lShlReady, lShlDone;

	coeffBank bank (
		.clk(clk), .reset(reset), .coeffWrite(coeffWrite), .coeffAddr(coeffAddr),
		.coeffData(coeffData), .coeffSel(coeffSel), .coeffOut(coeffOut)
	);

	gridSweep sweeper (
		.clk(clk), .reset(reset), .sweepStart(sweepStart), .evalDone(evalDone),
		.chebValue(chebValue), .evalStart(evalStart), .xValue(xValue),
		.resultValid(resultValid), .resultValue(resultValue),
		.resultIndex(resultIndex), .sweepDone(sweepDone), .busy(busy)
	);

	chebEvaluator evaluator (
		.clk(clk), .reset(reset), .evalStart(evalStart), .xValue(xValue),
		.coeffSel(coeffSel), .coeffOut(coeffOut),
		.lMultA(lMultA), .lMultB(lMultB), .lMultOut(lMultOut),
		.multA(multA), .multB(multB), .multOut(multOut),
		.lMacA(lMacA), .lMacB(lMacB), .lMacC(lMacC), .lMacOut(lMacOut),
		.lMsuA(lMsuA), .lMsuB(lMsuB), .lMsuC(lMsuC), .lMsuOut(lMsuOut),
		.lShlVar(lShlVar), .lShlShift(lShlShift), .lShlReady(lShlReady),
		.lShlDone(lShlDone), .lShlOut(lShlOut),
		.evalDone(evalDone), .chebValue(chebValue)
	);

	basicOps ops (
		.clk(clk), .reset(reset),
		.lMultA(lMultA), .lMultB(lMultB), .lMultOut(lMultOut),
		.multA(multA), .multB(multB), .multOut(multOut),
		.lMacA(lMacA), .lMacB(lMacB), .lMacC(lMacC), .lMacOut(lMacOut),
		.lMsuA(lMsuA), .lMsuB(lMsuB), .lMsuC(lMsuC), .lMsuOut(lMsuOut),
		.lShlVar(lShlVar), .lShlShift(lShlShift), .lShlReady(lShlReady),
		.lShlDone(lShlDone), .lShlOut(lShlOut)
	);

endmodule

`default_nettype wire

//--- source/lspChebPkg.sv
`default_nettype none

`include "lspCheb_config.svh"

package lspChebPkg;

	// Fixed-point words
	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;

	// Coefficient number 1..5 and grid position 0..50
	typedef logic [2:0] coeffIndex;
	typedef logic [5:0] gridIndex;

	//////////////////////////////////////////////////////////////////////
	// Cosine grid in Q15, cos(pi*k/50) rounded as in G.729
	//////////////////////////////////////////////////////////////////////
	localparam word16 cosGrid [`GRID_POINTS] = '{
		32760, 32703, 32509, 32187, 31738, 31164,
		30466, 29649, 28714, 27666, 26509, 25248,
		23886, 22431, 20887, 19260, 17557, 15786,
		13951, 12062, 10125, 8149, 6140, 4106,
		2057, 0, -2057, -4106, -6140, -8149,
		-10125, -12062, -13951, -15786, -17557, -19260,
		-20887, -22431, -23886, -25248, -26509, -27666,
		-28714, -29649, -30466, -31164, -31738, -32187,
		-32509, -32703, -32760
	};

endpackage

`default_nettype wire

//--- source/lspCheb_config.svh
`ifndef LSPCHEB_CONFIG_SVH
`define LSPCHEB_CONFIG_SVH

// Chebyshev series order, coefficients f1 to f5
`define POLY_ORDER 5

// Stored polynomial coefficients
`define COEFF_COUNT 5

// Cosine grid used by the root search
`define GRID_POINTS 51

`endif
